//--- msg_input.txt
# W adr sel data | R status | E strb data | P process | C clear | B mode hold
# Hex fields except B (decimal); B mode 0 ready high, 1 random, 2 low for hold cycles
B 1 0
# Full-select writes, low bus word first
W 0 f 33221100
W 0 f 77665544
E ff 7766554433221100
W 0 f bbaa9988
W 0 f ffeeddcc
E ff ffeeddccbbaa9988
# Sparse selects compacted in lane order
W 0 5 ee12ee11
W 0 e 151413ee
W 0 8 16eeeeee
W 0 f 1a191817
W 0 3 eeee1c1b
W 0 0 eeeeeeee
E ff 1817161514131211
# Process flushes the four byte tail
P
E 0f 000000001c1b1a19
R 000000d0
# Misuse in FlushClear, first error sticks
W 0 f deadbeef
R 000001d0
W 4 f 00000001
R 000001d0
C
R 00000010
# Ready held low fills the FIFO
B 2 0
W 0 f a0000000
W 0 f a0000001
W 0 f a0000002
W 0 f a0000003
W 0 f a0000004
W 0 f a0000005
W 0 f a0000006
W 0 f a0000007
W 0 f a0000008
W 0 f a0000009
W 0 f a000000a
W 0 f a000000b
W 0 f a000000c
W 0 f a000000d
W 0 f a000000e
W 0 f a000000f
W 0 f a0000010
W 0 f a0000011
R 00000028
# Next write waits until ready returns
B 2 20
W 0 f a0000012
W 0 f a0000013
E ff a0000001a0000000
E ff a0000003a0000002
E ff a0000005a0000004
E ff a0000007a0000006
E ff a0000009a0000008
E ff a000000ba000000a
E ff a000000da000000c
E ff a000000fa000000e
E ff a0000011a0000010
E ff a0000013a0000012
R 00000010
# Clear drops FIFO and packer contents
B 2 0
W 0 f b0000000
W 0 f b0000001
W 0 f b0000002
R 00000001
C
R 00000010
B 0 0
P
R 000000d0
W 4 f 00000001
R 000002d0
C
R 00000010

//--- compile.f
msg_pkg.sv
wb_msg_port.sv
msg_packer.sv
msg_fifo.sv
msg_flush_ctrl.sv
msg_ingest_top.sv
tb_msg_ingest.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_msg_ingest -f compile.f -o tb_msg_ingest
	./obj_dir/tb_msg_ingest > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -qF '*** FAILED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_msg_ingest.sv
/*
 * Testbench for the message ingest front end
 * Replays msg_input.txt over Wishbone, models the absorb side on the
 * MSG stream and checks output words, STATUS reads and process pulses
 */
`timescale 1ns/1ps

module tb_msg_ingest;
  import msg_pkg::*;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  wb_req_t   wb_i;
  wb_data_t  wb_dat_o;
  logic      wb_ack_o;
  logic      msg_valid_o;
  msg_word_t msg_o;
  logic      msg_ready_i;
  logic      process_o;

  // Words taken from MSG, oldest first
  msg_word_t got_q[$];

  // Ready model: 0 high, 1 random, 2 held low
  int          ready_mode = 0;
  int          hold_left = 0;
  logic [31:0] rng = 32'hcfda;

  // Last stalled beat, for the hold rule
  logic      stall_q = 1'b0;
  msg_word_t stall_word;

  int pulses = 0;
  int p_cmds = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int msg_errs = 0;
  int status_errs = 0;
  int proc_errs = 0;
  int other_errs = 0;

  msg_ingest_top DUT (
    .clk_i, .rst_ni,
    .wb_i, .wb_dat_o, .wb_ack_o,
    .msg_valid_o, .msg_o, .msg_ready_i,
    .process_o
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_msg(input msg_word_t got, input msg_word_t exp, input string what);
    if (got !== exp) begin
      msg_errs++;
      $display("ERR %0t: %s, got data %h strb %h, expected data %h strb %h",
               $time, what, got.data, got.strb, exp.data, exp.strb);
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      status_errs++;
      $display("ERR %0t: STATUS got %h (depth %0d empty %b full %b st %0d err %0d), expected %h",
               $time, got, got.depth, got.empty, got.full, got.flush_st, got.err, exp);
    end
  endtask

  // A command line with missing or unreadable fields
  task automatic verify_field_count(input int got, input int want, input logic [7:0] cmd);
    if (got != want) begin
      other_errs++;
      $display("Command '%c' in msg_input.txt gave %0d of %0d fields", cmd, got, want);
    end
  endtask

  // Classic single write, stb dropped in the ack cycle
  task automatic bus_write(input logic [WB_ADDR_W-1:0] adr, input wb_sel_t sel,
                           input wb_data_t dat);
    @(negedge clk_i);
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: sel};
    do @(negedge clk_i); while (!wb_ack_o);
    wb_i = '0;
  endtask

  task automatic bus_read(input logic [WB_ADDR_W-1:0] adr, output wb_data_t dat);
    @(negedge clk_i);
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: 4'hf};
    do @(negedge clk_i); while (!wb_ack_o);
    dat  = wb_dat_o;
    wb_i = '0;
  endtask

  // Counts newlines so the watchdog scales with the file
  function automatic int count_lines(input int fd);
    int ch;
    int n;
    n  = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == 10) begin
        n++;
      end
      ch = $fgetc(fd);
    end
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Absorb side model and monitors
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (hold_left > 0) begin
      hold_left--;
      if (hold_left == 0) begin
        ready_mode = 0;
      end
    end
    case (ready_mode)
      0: msg_ready_i = 1'b1;
      1: begin
        rng         = xorshift(rng);
        msg_ready_i = rng[4];
      end
      default: msg_ready_i = 1'b0;
    endcase
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Beat must hold while stalled
      if (stall_q && msg_valid_o) begin
        check_msg(msg_o, stall_word, "MSG word changed while stalled");
      end
      if (msg_valid_o && msg_ready_i) begin
        got_q.push_back(msg_o);
      end
      if (process_o) begin
        pulses++;
        if (msg_valid_o) begin
          proc_errs++;
          $display("ERR %0t: process_o pulsed with MSG words still queued", $time);
        end
      end
      stall_q    = msg_valid_o && !msg_ready_i;
      stall_word = msg_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the command file did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command replay
  //////////////////////////////////////////////////////////////////////

  task automatic run_commands(input int fd);
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [63:0] d;
    wb_data_t    rdat;
    msg_word_t   exp_word;
    logic        tail_due;
    int          n;
    int          ch;
    int          start;
    tail_due = 1'b0;
    while ($fscanf(fd, " %c", cmd) == 1) begin
      // Words listed right after P must have left before process_o
      if (cmd != "E" && cmd != "#") begin
        tail_due = 1'b0;
      end
      case (cmd)
        "#": begin
          do ch = $fgetc(fd); while (ch != 10 && ch != -1);
        end
        "W": begin
          n = $fscanf(fd, "%h %h %h", a, b, c);
          verify_field_count(n, 3, cmd);
          bus_write(a[WB_ADDR_W-1:0], b[3:0], c);
        end
        "R": begin
          n = $fscanf(fd, "%h", a);
          verify_field_count(n, 1, cmd);
          bus_read(ADDR_STATUS, rdat);
          check_status(status_t'(rdat), status_t'(a));
        end
        "E": begin
          n = $fscanf(fd, "%h %h", b, d);
          verify_field_count(n, 2, cmd);
          if (tail_due && got_q.size() == 0) begin
            proc_errs++;
            $display("ERR %0t: process_o pulsed before a flushed word left on MSG", $time);
          end
          while (got_q.size() == 0) begin
            @(negedge clk_i);
          end
          exp_word.data = d;
          exp_word.strb = b[7:0];
          check_msg(got_q.pop_front(), exp_word, "MSG word mismatch");
        end
        "P": begin
          p_cmds++;
          start = pulses;
          bus_write(ADDR_CTRL, 4'hf, 32'h1);
          // Sequence ends on the process pulse
          while (pulses == start) begin
            @(negedge clk_i);
          end
          tail_due = 1'b1;
        end
        "C": bus_write(ADDR_CTRL, 4'hf, 32'h2);
        "B": begin
          n = $fscanf(fd, "%d %d", a, b);
          verify_field_count(n, 2, cmd);
          @(posedge clk_i);
          ready_mode = a;
          hold_left  = b;
        end
        default: begin
          other_errs++;
          $display("Unknown command '%c' in msg_input.txt", cmd);
        end
      endcase
    end
  endtask

  initial begin : run
    int fd;
    int lines;
    rst_ni      = 1'b0;
    wb_i        = '0;
    msg_ready_i = 1'b1;
    fd = $fopen("msg_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open msg_input.txt for reading");
      $display("*** FAILED ***");
      $finish;
    end else begin
      lines = count_lines(fd);
      $fclose(fd);
      cycle_limit = 200 * (lines + 1);
      fd = $fopen("msg_input.txt", "r");
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      run_commands(fd);
      $fclose(fd);
      // Let stray words or pulses show up
      repeat (10) @(negedge clk_i);
      if (got_q.size() != 0) begin
        msg_errs++;
        $display("ERR %0t: %0d MSG words arrived with no expected entry",
                 $time, got_q.size());
      end
      if (pulses != p_cmds) begin
        proc_errs++;
        $display("ERR %0t: process_o pulsed %0d times for %0d process commands",
                 $time, pulses, p_cmds);
      end
      $display("Errors: msg %0d, status %0d, process %0d, other %0d",
               msg_errs, status_errs, proc_errs, other_errs);
      if (msg_errs + status_errs + proc_errs + other_errs == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

//--- msg_ingest_top.sv
/*
 * Message ingest front end
 * Wishbone port, byte packer, message FIFO and flush controller,
 * with the MSG valid/ready stream toward the absorb engine
 */
`timescale 1ns/1ps

module msg_ingest_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  msg_pkg::wb_req_t   wb_i,
  output msg_pkg::wb_data_t  wb_dat_o,
  output logic               wb_ack_o,
  output logic               msg_valid_o,
  output msg_pkg::msg_word_t msg_o,
  input  logic               msg_ready_i,
  output logic               process_o
);
  import msg_pkg::*;

  // Port to packer
  logic      wr_valid;
  bus_word_t wr_word;
  logic      wr_ready;

  // Packer to FIFO
  logic      pk_valid;
  msg_word_t pk_word;
  logic      pk_ready;

  // Control
  logic      process_req;
  logic      clear_req;
  logic      msg_write_busy;
  logic      msg_accept;
  logic      packer_flush;
  logic      packer_flush_done;
  flush_st_e flush_st;
  err_code_e err;

  // FIFO state
  logic    fifo_rvalid;
  logic    fifo_full;
  depth_t  fifo_depth;
  status_t status;

  ////////////////////////////////////////////////////////////////////////

  // STATUS image, unused bits read zero
  assign status = '{rsvd: '0, err: err, flush_st: flush_st, full: fifo_full,
                    empty: !fifo_rvalid, depth: fifo_depth};

  assign msg_valid_o = fifo_rvalid;

  wb_msg_port u_port (
    .clk_i, .rst_ni,
    .wb_i, .wb_dat_o, .wb_ack_o,
    .wr_valid_o       (wr_valid),
    .wr_o             (wr_word),
    .wr_ready_i       (wr_ready),
    .msg_accept_i     (msg_accept),
    .status_i         (status),
    .process_req_o    (process_req),
    .clear_req_o      (clear_req),
    .msg_write_busy_o (msg_write_busy)
  );

  msg_flush_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .process_req_i       (process_req),
    .clear_req_i         (clear_req),
    .msg_write_busy_i    (msg_write_busy),
    .packer_flush_o      (packer_flush),
    .packer_flush_done_i (packer_flush_done),
    .fifo_empty_i        (!fifo_rvalid),
    .msg_accept_o        (msg_accept),
    .process_o,
    .flush_st_o          (flush_st),
    .err_o               (err)
  );

  msg_packer u_packer (
    .clk_i, .rst_ni,
    .in_valid_i   (wr_valid),
    .in_i         (wr_word),
    .in_ready_o   (wr_ready),
    .out_valid_o  (pk_valid),
    .out_o        (pk_word),
    .out_ready_i  (pk_ready),
    .flush_i      (packer_flush),
    .flush_done_o (packer_flush_done),
    .clear_i      (clear_req)
  );

  msg_fifo u_fifo (
    .clk_i, .rst_ni,
    .clear_i  (clear_req),
    .wvalid_i (pk_valid),
    .wdata_i  (pk_word),
    .wready_o (pk_ready),
    .rvalid_o (fifo_rvalid),
    .rdata_o  (msg_o),
    .rready_i (msg_ready_i),
    .depth_o  (fifo_depth),
    .full_o   (fifo_full)
  );

endmodule

//--- msg_flush_ctrl.sv
/*
 * Flush controller
 * Sequences a process command through packer flush and FIFO drain,
 * pulses process_o at the end and holds a sticky first error code
 */
`timescale 1ns/1ps

module msg_flush_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                process_req_i,
  input  logic                clear_req_i,
  input  logic                msg_write_busy_i,
  output logic                packer_flush_o,
  input  logic                packer_flush_done_i,
  input  logic                fifo_empty_i,
  output logic                msg_accept_o,
  output logic                process_o,
  output msg_pkg::flush_st_e  flush_st_o,
  output msg_pkg::err_code_e  err_o
);
  import msg_pkg::*;

  flush_st_e flush_st_q;
  flush_st_e flush_st_d;
  err_code_e err_q;
  err_code_e err_d;

  always_comb begin
    flush_st_d = flush_st_q;
    case (flush_st_q)
      FlushIdle: begin
        if (process_req_i) begin
          flush_st_d = FlushPacker;
        end
      end
      // Wait for the tail word to reach the FIFO
      FlushPacker: begin
        if (packer_flush_done_i) begin
          flush_st_d = FlushFifo;
        end
      end
      FlushFifo: begin
        if (fifo_empty_i) begin
          flush_st_d = FlushClear;
        end
      end
      // Hold until the absorb side is done
      FlushClear: begin
        flush_st_d = FlushClear;
      end
      default: begin
        flush_st_d = FlushIdle;
      end
    endcase
    // Clear wins from any state
    if (clear_req_i) begin
      flush_st_d = FlushIdle;
    end
  end

  // Sticky first error
  always_comb begin
    err_d = err_q;
    if (clear_req_i) begin
      err_d = ErrNone;
    end else if (err_q == ErrNone) begin
      if (msg_write_busy_i) begin
        err_d = ErrMsgDuringFlush;
      end else if (process_req_i && (flush_st_q != FlushIdle)) begin
        err_d = ErrProcessBusy;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_st_q <= FlushIdle;
      err_q      <= ErrNone;
    end else begin
      flush_st_q <= flush_st_d;
      err_q      <= err_d;
    end
  end

  assign packer_flush_o = (flush_st_q == FlushIdle) && process_req_i && !clear_req_i;
  assign process_o      = (flush_st_q == FlushFifo) && fifo_empty_i;
  assign msg_accept_o   = (flush_st_q == FlushIdle);
  assign flush_st_o     = flush_st_q;
  assign err_o          = err_q;

  flush_st_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_st_q inside {FlushIdle, FlushPacker, FlushFifo, FlushClear});

endmodule

//--- msg_fifo.sv
/*
 * Message FIFO
 * Registered circular buffer of message words with synchronous clear,
 * a depth count and a full flag
 */
`timescale 1ns/1ps

module msg_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               wvalid_i,
  input  msg_pkg::msg_word_t wdata_i,
  output logic               wready_o,
  output logic               rvalid_o,
  output msg_pkg::msg_word_t rdata_o,
  input  logic               rready_i,
  output msg_pkg::depth_t    depth_o,
  output logic               full_o
);
  import msg_pkg::*;

  msg_word_t mem [MSG_DEPTH];

  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  depth_t           count_q;

  logic wr_fire;
  logic rd_fire;

  // Pointer increment with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(MSG_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o   = (count_q == depth_t'(MSG_DEPTH));
  assign wready_o = !full_o;
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem[rptr_q];
  assign depth_o  = count_q;

  assign wr_fire = wvalid_i && wready_o;
  assign rd_fire = rvalid_o && rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_fire) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (rd_fire) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      // Count tracks pushes minus pops
      if (wr_fire && !rd_fire) begin
        count_q <= count_q + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  depth_bound_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    depth_o <= depth_t'(MSG_DEPTH));

endmodule

//--- msg_packer.sv
/*
 * Byte packer
 * Appends the selected lanes of each bus word to a byte stream and
 * emits full 64-bit message words, or the partial tail on flush
 */
`timescale 1ns/1ps

module msg_packer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               in_valid_i,
  input  msg_pkg::bus_word_t in_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output msg_pkg::msg_word_t out_o,
  input  logic               out_ready_i,
  input  logic               flush_i,
  output logic               flush_done_o,
  input  logic               clear_i
);
  import msg_pkg::*;

  // Pending bytes, valid only below fill_q
  msg_data_t         acc_q;
  logic [FILL_W-1:0] fill_q;
  msg_word_t         out_q;
  logic              out_valid_q;
  logic              flush_pend_q;

  // Accumulator with the new lanes appended
  logic [MSG_W+WB_DATA_W-1:0] stream;
  logic [FILL_W:0]            stream_cnt;
  logic                       stream_full;

  logic      in_fire;
  logic      out_fire;
  logic      flush_emit;
  msg_strb_t tail_strb;
  msg_data_t tail_data;

  always_comb begin
    stream     = {{WB_DATA_W{1'b0}}, acc_q};
    stream_cnt = {1'b0, fill_q};
    // Compact selected lanes, lowest lane first
    for (int i = 0; i < WB_BYTES; i++) begin
      if (in_i.sel[i]) begin
        stream[8*stream_cnt +: 8] = in_i.data[8*i +: 8];
        stream_cnt                = stream_cnt + 1'b1;
      end
    end
  end

  assign stream_full = stream_cnt >= MSG_BYTES;

  // Partial word, low n strobes and stale bytes zeroed
  assign tail_strb = (msg_strb_t'(1) << fill_q) - msg_strb_t'(1);
  always_comb begin
    for (int b = 0; b < MSG_BYTES; b++) begin
      tail_data[8*b +: 8] = tail_strb[b] ? acc_q[8*b +: 8] : 8'h00;
    end
  end

  assign in_ready_o = !out_valid_q && !flush_pend_q;
  assign in_fire    = in_valid_i && in_ready_o;
  assign out_fire   = out_valid_q && out_ready_i;
  assign flush_emit = flush_pend_q && !out_valid_q && (fill_q != '0);

  // Done once nothing is pending and no word waits at the output
  assign flush_done_o = flush_pend_q && !out_valid_q && (fill_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q       <= '0;
      out_valid_q  <= 1'b0;
      flush_pend_q <= 1'b0;
    end else if (clear_i) begin
      fill_q       <= '0;
      out_valid_q  <= 1'b0;
      flush_pend_q <= 1'b0;
    end else begin
      if (out_fire) begin
        out_valid_q <= 1'b0;
      end
      if (in_fire) begin
        if (stream_full) begin
          out_valid_q <= 1'b1;
          fill_q      <= FILL_W'(stream_cnt - MSG_BYTES);
        end else begin
          fill_q <= stream_cnt[FILL_W-1:0];
        end
      end else if (flush_emit) begin
        out_valid_q <= 1'b1;
        fill_q      <= '0;
      end
      if (flush_i) begin
        flush_pend_q <= 1'b1;
      end else if (flush_done_o) begin
        flush_pend_q <= 1'b0;
      end
    end
  end

  // Byte payload
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      if (stream_full) begin
        out_q <= '{data: stream[MSG_W-1:0], strb: '1};
        acc_q <= MSG_W'(stream[MSG_W +: WB_DATA_W]);
      end else begin
        acc_q <= stream[MSG_W-1:0];
      end
    end else if (flush_emit) begin
      out_q <= '{data: tail_data, strb: tail_strb};
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

  // Controller only flushes after a prior done
  flush_done_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flush_i && flush_done_o));

  // Bus port must not offer message data during a flush
  no_input_in_flush_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_pend_q |-> !in_valid_i);

endmodule

//--- wb_msg_port.sv
/*
 * Wishbone classic slave for the message ingest block
 * Decodes the message window, CTRL and STATUS offsets, hands message
 * writes to the packer and acks each access with a single-cycle pulse
 */
`timescale 1ns/1ps

module wb_msg_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  msg_pkg::wb_req_t   wb_i,
  output msg_pkg::wb_data_t  wb_dat_o,
  output logic               wb_ack_o,
  output logic               wr_valid_o,
  output msg_pkg::bus_word_t wr_o,
  input  logic               wr_ready_i,
  input  logic               msg_accept_i,
  input  msg_pkg::status_t   status_i,
  output logic               process_req_o,
  output logic               clear_req_o,
  output logic               msg_write_busy_o
);
  import msg_pkg::*;

  logic      ack_q;
  logic      wr_valid_q;
  logic      process_req_q;
  logic      clear_req_q;
  logic      busy_q;
  wb_data_t  dat_q;
  bus_word_t wr_q;

  logic req_new;
  logic is_msg_wr;
  logic is_ctrl_wr;
  logic is_status_rd;
  logic wr_fire;

  // New access only when not already acked or handed to the packer
  assign req_new = wb_i.cyc && wb_i.stb && !ack_q && !wr_valid_q;

  // Offset decode
  assign is_msg_wr    = wb_i.we && (wb_i.adr == ADDR_MSG);
  assign is_ctrl_wr   = wb_i.we && (wb_i.adr == ADDR_CTRL);
  assign is_status_rd = !wb_i.we && (wb_i.adr == ADDR_STATUS);

  assign wr_fire = wr_valid_q && wr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q         <= 1'b0;
      wr_valid_q    <= 1'b0;
      process_req_q <= 1'b0;
      clear_req_q   <= 1'b0;
      busy_q        <= 1'b0;
    end else begin
      // Pulses default low
      ack_q         <= 1'b0;
      process_req_q <= 1'b0;
      clear_req_q   <= 1'b0;
      busy_q        <= 1'b0;
      if (wr_fire) begin
        // Packer took the word, ack next cycle
        wr_valid_q <= 1'b0;
        ack_q      <= 1'b1;
      end else if (req_new) begin
        if (is_msg_wr) begin
          if (msg_accept_i) begin
            wr_valid_q <= 1'b1;
          end else begin
            // Flush in progress, ack and drop
            ack_q  <= 1'b1;
            busy_q <= 1'b1;
          end
        end else begin
          ack_q <= 1'b1;
          if (is_ctrl_wr) begin
            process_req_q <= wb_i.dat[CTRL_PROCESS_BIT];
            clear_req_q   <= wb_i.dat[CTRL_CLEAR_BIT];
          end
        end
      end
    end
  end

  // Captured write word and read data
  always_ff @(posedge clk_i) begin
    if (req_new) begin
      wr_q  <= '{data: wb_i.dat, sel: wb_i.sel};
      // Message window and unmapped offsets read as zero
      dat_q <= is_status_rd ? wb_data_t'(status_i) : '0;
    end
  end

  assign wb_ack_o         = ack_q;
  assign wb_dat_o         = dat_q;
  assign wr_valid_o       = wr_valid_q;
  assign wr_o             = wr_q;
  assign process_req_o    = process_req_q;
  assign clear_req_o      = clear_req_q;
  assign msg_write_busy_o = busy_q;

  // Master drops stb after ack, so a second ack would be a stray
  ack_single_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

endmodule

//--- msg_pkg.sv
/*
 * Message ingest shared definitions
 * Bus and message widths, FIFO depth, register map, payload structs,
 * flush state encoding, error codes and the STATUS register image
 */
package msg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and depth
  //////////////////////////////////////////////////////////////////////

  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;
  localparam int MSG_W     = 64;
  localparam int MSG_DEPTH = 8;

  // Derived sizes
  localparam int WB_BYTES     = WB_DATA_W / 8;
  localparam int MSG_BYTES    = MSG_W / 8;
  localparam int FILL_W       = $clog2(MSG_BYTES);
  localparam int PTR_W        = $clog2(MSG_DEPTH);
  localparam int DEPTH_W      = $clog2(MSG_DEPTH + 1);
  localparam int STATUS_PAD_W = WB_DATA_W - DEPTH_W - 6;

  // Register offsets, byte addressed
  localparam logic [WB_ADDR_W-1:0] ADDR_MSG    = 4'h0;
  localparam logic [WB_ADDR_W-1:0] ADDR_CTRL   = 4'h4;
  localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'h8;

  // CTRL register bits
  localparam int CTRL_PROCESS_BIT = 0;
  localparam int CTRL_CLEAR_BIT   = 1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_BYTES-1:0]  wb_sel_t;
  typedef logic [MSG_W-1:0]     msg_data_t;
  typedef logic [MSG_BYTES-1:0] msg_strb_t;
  typedef logic [DEPTH_W-1:0]   depth_t;

  // One FIFO entry, also the MSG output beat
  typedef struct packed {
    msg_data_t data;
    msg_strb_t strb;
  } msg_word_t;

  // Message write from the bus port to the packer
  typedef struct packed {
    wb_data_t data;
    wb_sel_t  sel;
  } bus_word_t;

  // Master to slave Wishbone classic signals
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    wb_data_t             dat;
    wb_sel_t              sel;
  } wb_req_t;

  typedef enum logic [1:0] {
    FlushIdle,
    FlushPacker,
    FlushFifo,
    FlushClear
  } flush_st_e;

  typedef enum logic [1:0] {
    ErrNone,
    ErrMsgDuringFlush,
    ErrProcessBusy
  } err_code_e;

  // STATUS image, first field lands in the top bits
  typedef struct packed {
    logic [STATUS_PAD_W-1:0] rsvd;
    err_code_e               err;
    flush_st_e               flush_st;
    logic                    full;
    logic                    empty;
    depth_t                  depth;
  } status_t;

endpackage
